/* source/vshift_pkg.sv */
`default_nettype none

package vshift_pkg;

  localparam int vlen = 128;
  localparam int xlen = 32;

  localparam int byte_width  = 8;
  localparam int hword_width = 16;
  localparam int word_width  = 32;

  localparam int num_bytes  = vlen / byte_width;
  localparam int num_hwords = vlen / hword_width;
  localparam int num_words  = vlen / word_width;

  // only the low log2(sew) bits of an amount matter
  localparam int amt_byte_width  = $clog2(byte_width);
  localparam int amt_hword_width = $clog2(hword_width);
  localparam int amt_word_width  = $clog2(word_width);

  localparam int rob_depth_width = 4;

  typedef enum logic [2:0] {
    vv = 3'b000,
    vi = 3'b011,
    vx = 3'b100
  } funct3_e;

  typedef enum logic [5:0] {
    sll  = 6'b100101,
    srl  = 6'b101000,
    sra  = 6'b101001,
    ssrl = 6'b101010,
    ssra = 6'b101011
  } shift_funct6_e;

  // 2'b11 reserved
  typedef enum logic [1:0] {
    eew8  = 2'b00,
    eew16 = 2'b01,
    eew32 = 2'b10
  } eew_e;

  typedef enum logic [1:0] {
    rnu = 2'b00,
    rne = 2'b01,
    rdn = 2'b10,
    rod = 2'b11
  } vxrm_e;

  typedef enum logic [1:0] {
    kind_sll = 2'b00,
    kind_srl = 2'b01,
    kind_sra = 2'b10
  } shift_kind_e;

  // rs1_data holds the immediate for the vi form
  typedef struct packed {
    logic [rob_depth_width-1:0] rob_entry;
    shift_funct6_e              funct6;
    funct3_e                    funct3;
    vxrm_e                      vxrm;
    logic [vlen-1:0]            vs2_data;
    logic [vlen-1:0]            vs1_data;
    logic [xlen-1:0]            rs1_data;
    eew_e                       vs2_eew;
  } shift_uop_t;

  typedef struct packed {
    logic [rob_depth_width-1:0]                  rob_entry;
    shift_kind_e                                 kind;
    logic                                        scaling;
    vxrm_e                                       vxrm;
    eew_e                                        eew;
    logic [vlen-1:0]                             src_data;
    logic [num_bytes-1:0][amt_byte_width-1:0]    amount8;
    logic [num_hwords-1:0][amt_hword_width-1:0]  amount16;
    logic [num_words-1:0][amt_word_width-1:0]    amount32;
  } decoded_uop_t;

  typedef struct packed {
    logic [rob_depth_width-1:0]              rob_entry;
    shift_kind_e                             kind;
    logic                                    scaling;
    vxrm_e                                   vxrm;
    eew_e                                    eew;
    logic [num_bytes-1:0][byte_width-1:0]    product8;
    logic [num_bytes-1:0][byte_width-1:0]    round_bits8;
    logic [num_hwords-1:0][hword_width-1:0]  product16;
    logic [num_hwords-1:0][hword_width-1:0]  round_bits16;
    logic [num_words-1:0][word_width-1:0]    product32;
    logic [num_words-1:0][word_width-1:0]    round_bits32;
  } shifted_uop_t;

  typedef struct packed {
    logic [rob_depth_width-1:0] rob_entry;
    logic [vlen-1:0]            w_data;
  } shift_result_t;

endpackage

`default_nettype wire

/* source/vshift_lane.sv */
`default_nettype none

module vshift_lane #(
  parameter int elem_width = 8
) (
  input  vshift_pkg::shift_kind_e        kind,
  input  logic [elem_width-1:0]          operand,
  input  logic [$clog2(elem_width)-1:0]  amount,
  output logic [elem_width-1:0]          product,
  output logic [elem_width-1:0]          round_bits
);
  import vshift_pkg::*;

  logic [2*elem_width-1:0] wide;
  logic [2*elem_width-1:0] shifted;

  // operand sits in the high half, low half catches what falls out
  assign wide = {operand, {elem_width{1'b0}}};

  always_comb begin
    case (kind)
      kind_sll: shifted = wide << amount;
      kind_sra: shifted = $signed(wide) >>> amount;
      default:  shifted = wide >> amount;
    endcase
  end

  assign product    = shifted[2*elem_width-1:elem_width];
  assign round_bits = shifted[elem_width-1:0];

endmodule

`default_nettype wire

/* source/vshift_decode.sv */
`default_nettype none

module vshift_decode (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     uop_valid,
  input  vshift_pkg::shift_uop_t   uop,
  output logic                     dec_valid,
  output vshift_pkg::decoded_uop_t dec
);
  import vshift_pkg::*;

  logic         supported;
  logic         eew_ok;
  logic         vector_amt;
  shift_kind_e  kind;
  logic         scaling;
  decoded_uop_t dec_next;

  always_comb begin
    supported = 1'b1;
    kind      = kind_sll;
    scaling   = 1'b0;
    case (uop.funct6)
      sll: kind = kind_sll;
      srl: kind = kind_srl;
      sra: kind = kind_sra;
      ssrl: begin
        kind    = kind_srl;
        scaling = 1'b1;
      end
      ssra: begin
        kind    = kind_sra;
        scaling = 1'b1;
      end
      default: supported = 1'b0;
    endcase
  end

  assign eew_ok     = uop.vs2_eew inside {eew8, eew16, eew32};
  assign vector_amt = (uop.funct3 == vv);

  // vx and vi broadcast the low bits of rs1
  always_comb begin
    dec_next           = '0;
    dec_next.rob_entry = uop.rob_entry;
    dec_next.kind      = kind;
    dec_next.scaling   = scaling;
    dec_next.vxrm      = uop.vxrm;
    dec_next.eew       = uop.vs2_eew;
    dec_next.src_data  = uop.vs2_data;
    case (uop.vs2_eew)
      eew8: begin
        for (int i = 0; i < num_bytes; i++) begin
          dec_next.amount8[i] = vector_amt ? uop.vs1_data[i*byte_width +: amt_byte_width]
                                           : uop.rs1_data[amt_byte_width-1:0];
        end
      end
      eew16: begin
        for (int i = 0; i < num_hwords; i++) begin
          dec_next.amount16[i] = vector_amt ? uop.vs1_data[i*hword_width +: amt_hword_width]
                                            : uop.rs1_data[amt_hword_width-1:0];
        end
      end
      default: begin
        for (int i = 0; i < num_words; i++) begin
          dec_next.amount32[i] = vector_amt ? uop.vs1_data[i*word_width +: amt_word_width]
                                            : uop.rs1_data[amt_word_width-1:0];
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= uop_valid & supported & eew_ok;
    end
  end

  always_ff @(posedge clk) begin
    dec <= dec_next;
  end

  // issuer must not send the reserved element width
  a_no_reserved_eew: assert property (@(posedge clk) disable iff (!rst_n)
    uop_valid |-> uop.vs2_eew inside {eew8, eew16, eew32});

endmodule

`default_nettype wire

/* source/vshift_array.sv */
`default_nettype none

module vshift_array (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     dec_valid,
  input  vshift_pkg::decoded_uop_t dec,
  output logic                     sh_valid,
  output vshift_pkg::shifted_uop_t sh
);
  import vshift_pkg::*;

  logic [num_bytes-1:0][byte_width-1:0]   product8;
  logic [num_bytes-1:0][byte_width-1:0]   round_bits8;
  logic [num_hwords-1:0][hword_width-1:0] product16;
  logic [num_hwords-1:0][hword_width-1:0] round_bits16;
  logic [num_words-1:0][word_width-1:0]   product32;
  logic [num_words-1:0][word_width-1:0]   round_bits32;

  // all widths run in parallel, round stage picks by eew
  for (genvar i = 0; i < num_bytes; i++) begin : g_lane8
    vshift_lane #(.elem_width(byte_width)) lane_inst (
      .kind       (dec.kind),
      .operand    (dec.src_data[i*byte_width +: byte_width]),
      .amount     (dec.amount8[i]),
      .product    (product8[i]),
      .round_bits (round_bits8[i])
    );
  end

  for (genvar i = 0; i < num_hwords; i++) begin : g_lane16
    vshift_lane #(.elem_width(hword_width)) lane_inst (
      .kind       (dec.kind),
      .operand    (dec.src_data[i*hword_width +: hword_width]),
      .amount     (dec.amount16[i]),
      .product    (product16[i]),
      .round_bits (round_bits16[i])
    );
  end

  for (genvar i = 0; i < num_words; i++) begin : g_lane32
    vshift_lane #(.elem_width(word_width)) lane_inst (
      .kind       (dec.kind),
      .operand    (dec.src_data[i*word_width +: word_width]),
      .amount     (dec.amount32[i]),
      .product    (product32[i]),
      .round_bits (round_bits32[i])
    );
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sh_valid <= 1'b0;
    end else begin
      sh_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    sh.rob_entry    <= dec.rob_entry;
    sh.kind         <= dec.kind;
    sh.scaling      <= dec.scaling;
    sh.vxrm         <= dec.vxrm;
    sh.eew          <= dec.eew;
    sh.product8     <= product8;
    sh.round_bits8  <= round_bits8;
    sh.product16    <= product16;
    sh.round_bits16 <= round_bits16;
    sh.product32    <= product32;
    sh.round_bits32 <= round_bits32;
  end

endmodule

`default_nettype wire

/* source/vshift_round.sv */
`default_nettype none

module vshift_round (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      sh_valid,
  input  vshift_pkg::shifted_uop_t  sh,
  output logic                      result_valid,
  output vshift_pkg::shift_result_t result
);
  import vshift_pkg::*;

  logic                                   apply_round;
  logic [num_bytes-1:0]                   inc8;
  logic [num_hwords-1:0]                  inc16;
  logic [num_words-1:0]                   inc32;
  logic [num_bytes-1:0][byte_width-1:0]   res8;
  logic [num_hwords-1:0][hword_width-1:0] res16;
  logic [num_words-1:0][word_width-1:0]   res32;
  logic [vlen-1:0]                        w_data_next;

  // half is bit a-1 of the source, sticky the bits below it
  function automatic logic round_inc(vxrm_e mode, logic half, logic sticky, logic lsb);
    case (mode)
      rnu:     return half;
      rne:     return half & (sticky | lsb);
      rdn:     return 1'b0;
      default: return ~lsb & (half | sticky);
    endcase
  endfunction

  // plain shifts pass through with a zero increment
  assign apply_round = sh.scaling;

  for (genvar i = 0; i < num_bytes; i++) begin : g_round8
    assign inc8[i] = apply_round & round_inc(sh.vxrm, sh.round_bits8[i][byte_width-1],
                                             |sh.round_bits8[i][byte_width-2:0],
                                             sh.product8[i][0]);
    assign res8[i] = sh.product8[i] + byte_width'(inc8[i]);
  end

  for (genvar i = 0; i < num_hwords; i++) begin : g_round16
    assign inc16[i] = apply_round & round_inc(sh.vxrm, sh.round_bits16[i][hword_width-1],
                                              |sh.round_bits16[i][hword_width-2:0],
                                              sh.product16[i][0]);
    assign res16[i] = sh.product16[i] + hword_width'(inc16[i]);
  end

  for (genvar i = 0; i < num_words; i++) begin : g_round32
    assign inc32[i] = apply_round & round_inc(sh.vxrm, sh.round_bits32[i][word_width-1],
                                              |sh.round_bits32[i][word_width-2:0],
                                              sh.product32[i][0]);
    assign res32[i] = sh.product32[i] + word_width'(inc32[i]);
  end

  always_comb begin
    case (sh.eew)
      eew8:    w_data_next = res8;
      eew16:   w_data_next = res16;
      default: w_data_next = res32;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= sh_valid;
    end
  end

  always_ff @(posedge clk) begin
    result.rob_entry <= sh.rob_entry;
    result.w_data    <= w_data_next;
  end

  // any X here came from upstream stages or the issuer
  a_known_result: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> !$isunknown(result.w_data));

endmodule

`default_nettype wire

/* source/vshift_unit.sv */
`default_nettype none

module vshift_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      uop_valid,
  input  vshift_pkg::shift_uop_t    uop,
  output logic                      result_valid,
  output vshift_pkg::shift_result_t result
);
  import vshift_pkg::*;

  logic         dec_valid;
  decoded_uop_t dec;
  logic         sh_valid;
  shifted_uop_t sh;

  // three stages, one cycle each
  vshift_decode decode_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .uop_valid (uop_valid),
    .uop       (uop),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  vshift_array array_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec       (dec),
    .sh_valid  (sh_valid),
    .sh        (sh)
  );

  vshift_round round_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .sh_valid     (sh_valid),
    .sh           (sh),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

/* tests/vshift_model.svh */
function automatic int elem_bits(eew_e eew);
  case (eew)
    eew8:    return 8;
    eew16:   return 16;
    default: return 32;
  endcase
endfunction

function automatic logic produces_result(shift_uop_t u);
  return (u.funct6 inside {sll, srl, sra, ssrl, ssra}) &&
         (u.vs2_eew inside {eew8, eew16, eew32});
endfunction

// one element of width w, amount already taken from vs1 or rs1
function automatic logic [31:0] expected_element(shift_funct6_e f6, vxrm_e mode, int w,
                                                 logic [31:0] elem, logic [31:0] amt);
  logic [63:0] mask;
  logic [63:0] src;
  logic [63:0] v;
  logic        r;
  logic        half;
  logic        below;
  logic        discarded;
  int          a;
  mask = (64'd1 << w) - 1;
  a    = int'(amt & 32'(w - 1));
  src  = {32'd0, elem} & mask;
  // sign fill reaches far enough for any amount below w
  if ((f6 == sra || f6 == ssra) && src[w-1]) begin
    src = src | ~mask;
  end
  if (f6 == sll) begin
    v = src << a;
  end else begin
    v = src >> a;
  end
  r = 1'b0;
  if ((f6 == ssrl || f6 == ssra) && a > 0) begin
    half      = src[a-1];
    below     = |(src & ((64'd1 << (a - 1)) - 1));
    discarded = |(src & ((64'd1 << a) - 1));
    case (mode)
      rnu:     r = half;
      rne:     r = half & (below | v[0]);
      rdn:     r = 1'b0;
      default: r = ~v[0] & discarded;
    endcase
  end
  return 32'((v + 64'(r)) & mask);
endfunction

function automatic logic [vlen-1:0] expected_data(shift_uop_t u);
  logic [vlen-1:0] data;
  logic [31:0]     elem;
  logic [31:0]     amt;
  int              w;
  w    = elem_bits(u.vs2_eew);
  data = '0;
  for (int i = 0; i < vlen / w; i++) begin
    elem = 32'(u.vs2_data >> (i * w));
    amt  = (u.funct3 == vv) ? 32'(u.vs1_data >> (i * w)) : u.rs1_data;
    data = data | (vlen'(expected_element(u.funct6, u.vxrm, w, elem, amt)) << (i * w));
  end
  return data;
endfunction

/* tests/vshift_unit_tb.sv */
`default_nettype none

module vshift_unit_tb;
  import vshift_pkg::*;

  `include "vshift_model.svh"

  typedef struct packed {
    logic                       has_result;
    logic [rob_depth_width-1:0] rob_entry;
    logic [vlen-1:0]            w_data;
  } expect_t;

  localparam int clk_period = 40;
  localparam int plain_reps = 4;
  localparam int num_uops   = 3 * 3 * 3 * plain_reps + 2 * 4 * 3 * 4 + 3 * 2 * 2 + 16 + 8;

  logic                       clk;
  logic                       rst_n;
  logic                       uop_valid;
  shift_uop_t                 uop;
  string                      uop_name;
  logic                       result_valid;
  shift_result_t              result;
  expect_t                    exp_q[$];
  string                      name_q[$];
  expect_t                    due;
  string                      due_name;
  logic [rob_depth_width-1:0] next_tag;

  shift_funct6_e plain_ops[3] = '{sll, srl, sra};
  shift_funct6_e scale_ops[2] = '{ssrl, ssra};
  shift_funct6_e all_ops[5]   = '{sll, srl, sra, ssrl, ssra};
  funct3_e       forms[3]     = '{vv, vx, vi};
  eew_e          widths[3]    = '{eew8, eew16, eew32};
  vxrm_e         modes[4]     = '{rnu, rne, rdn, rod};
  logic [5:0]    bad_codes[4] = '{6'b000000, 6'b100100, 6'b101100, 6'b111111};

  vshift_unit vshift_unit_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopped at first failure");
  endtask

  // one entry per cycle, idle cycles expect no result
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q.delete();
      name_q.delete();
      due      = '0;
      due_name = "reset";
    end else begin
      exp_q.push_back({uop_valid && produces_result(uop), uop.rob_entry, expected_data(uop)});
      name_q.push_back(uop_name);
      if (exp_q.size() == 3) begin
        due      = exp_q.pop_front();
        due_name = name_q.pop_front();
      end
    end
  end

  // outputs settle between rising edges
  a_valid_match: assert property (@(negedge clk) disable iff (!rst_n)
    result_valid == due.has_result)
    else stop_with_error($sformatf("[ERROR] %s: expected result_valid %0b, actual %0b",
                                   due_name, due.has_result, result_valid));

  a_tag_match: assert property (@(negedge clk) disable iff (!rst_n)
    result_valid |-> result.rob_entry == due.rob_entry)
    else stop_with_error($sformatf("[ERROR] %s: expected tag %0d, actual %0d",
                                   due_name, due.rob_entry, result.rob_entry));

  a_data_match: assert property (@(negedge clk) disable iff (!rst_n)
    result_valid |-> result.w_data == due.w_data)
    else stop_with_error($sformatf("[ERROR] %s: expected data %h, actual %h",
                                   due_name, due.w_data, result.w_data));

  function automatic shift_uop_t random_uop(shift_funct6_e f6, funct3_e f3, eew_e eew,
                                            vxrm_e mode);
    shift_uop_t u;
    u.rob_entry = '0;
    u.funct6    = f6;
    u.funct3    = f3;
    u.vxrm      = mode;
    u.vs2_data  = {$urandom, $urandom, $urandom, $urandom};
    u.vs1_data  = {$urandom, $urandom, $urandom, $urandom};
    // 5-bit immediate for vi
    u.rs1_data  = (f3 == vi) ? xlen'($urandom % 32) : $urandom;
    u.vs2_eew   = eew;
    return u;
  endfunction

  task automatic issue(input string name, input shift_uop_t u);
    @(posedge clk);
    u.rob_entry = next_tag;
    next_tag    = next_tag + 1'b1;
    uop_valid  <= 1'b1;
    uop        <= u;
    uop_name   <= name;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      uop_valid <= 1'b0;
      uop_name  <= "idle";
    end
  endtask

  initial begin
    shift_uop_t u;
    void'($urandom(32'h0fa31537));
    rst_n     <= 1'b0;
    uop_valid <= 1'b0;
    uop       <= '0;
    uop_name  <= "idle";
    next_tag   = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    idle(4);

    foreach (plain_ops[o]) begin
      foreach (widths[e]) begin
        foreach (forms[f]) begin
          repeat (plain_reps) begin
            issue("plain_shift", random_uop(plain_ops[o], forms[f], widths[e],
                                            modes[$urandom % 4]));
          end
        end
      end
    end

    // amount 0 and the largest amount for every width
    foreach (scale_ops[o]) begin
      foreach (modes[m]) begin
        foreach (widths[e]) begin
          u = random_uop(scale_ops[o], vx, widths[e], modes[m]);
          u.rs1_data[4:0] = 5'd0;
          issue("scaling_amount_zero", u);
          u.rs1_data = $urandom | 32'h1f;
          issue("scaling_amount_max", u);
          repeat (2) begin
            issue("scaling_shift", random_uop(scale_ops[o], vv, widths[e], modes[m]));
          end
        end
      end
    end

    foreach (widths[e]) begin
      foreach (forms[f]) begin
        if (forms[f] != vv) begin
          u = random_uop(srl, forms[f], widths[e], rnu);
          u.vs1_data = '1;
          issue("broadcast", u);
          u = random_uop(sll, forms[f], widths[e], rnu);
          u.vs1_data = '0;
          issue("broadcast", u);
        end
      end
    end

    repeat (16) begin
      issue("back_to_back", random_uop(all_ops[$urandom % 5], forms[$urandom % 3],
                                       widths[$urandom % 3], modes[$urandom % 4]));
    end

    idle(3);
    foreach (bad_codes[k]) begin
      u = random_uop(sll, vx, widths[$urandom % 3], rnu);
      u.funct6 = shift_funct6_e'(bad_codes[k]);
      issue("unsupported_funct6", u);
      issue("after_unsupported", random_uop(all_ops[$urandom % 5], vv,
                                            widths[$urandom % 3], modes[$urandom % 4]));
    end

    idle(6);
    $display("No errors");
    $finish;
  end

  initial begin
    repeat (num_uops + 20) @(posedge clk);
    stop_with_error($sformatf("watchdog expired after %0d clock periods, run did not finish",
                              num_uops + 20));
  end

endmodule

`default_nettype wire

/* vshift_unit.f */
+incdir+tests
source/vshift_pkg.sv
source/vshift_lane.sv
source/vshift_decode.sv
source/vshift_array.sv
source/vshift_round.sv
source/vshift_unit.sv
tests/vshift_unit_tb.sv
